/* hdl/pm_consts.svh */
`ifndef PM_CONSTS_SVH
`define PM_CONSTS_SVH

// Metric and trellis dimensions
`define PM_WIDTH        8
`define PM_NUM_STATES   64
`define PM_STATE_W      6
`define PM_GROUP_SIZE   8
`define PM_NUM_GROUPS   8

// Saturation bounds of a normalized metric
`define PM_SAT_MIN      (-128)
`define PM_SAT_MAX      127

// Active state count selector
`define PM_MODE_64      2'd0
`define PM_MODE_32      2'd1
`define PM_MODE_16      2'd2
`define PM_MODE_8       2'd3

`endif

/* hdl/pm_pkg.sv */
`include "pm_consts.svh"

package pm_pkg;

	// One signed path metric
	typedef logic signed [`PM_WIDTH-1:0] pm_metric_t;

	// Trellis state index
	typedef logic [`PM_STATE_W-1:0] pm_state_t;

	// Active state count, see PM_MODE_* codes
	typedef logic [1:0] pm_mode_t;

	// All metrics side by side, state 0 in the low bits
	typedef logic [`PM_NUM_STATES*`PM_WIDTH-1:0] pm_vec_t;

	// Result of one compare stage
	typedef struct packed {
		pm_metric_t metric;
		pm_state_t  state;
	} pm_max_t;

	// Left candidate holds the lower states and wins on a tie
	function automatic pm_max_t pm_pick(
		input pm_max_t left,
		input pm_max_t right
	);
		if ($signed(left.metric) >= $signed(right.metric)) begin
			return left;
		end
		return right;
	endfunction

endpackage

/* hdl/pm_max_group.sv */
`timescale 1ns/1ps

`include "pm_consts.svh"

// Maximum metric and its state inside one group of eight states
module pm_max_group #(
	parameter int BASE_STATE = 0
) (
	input  logic [`PM_GROUP_SIZE*`PM_WIDTH-1:0] pm_i,
	output pm_pkg::pm_max_t                     best_o
);

	pm_pkg::pm_max_t leaf_s [`PM_GROUP_SIZE];
	pm_pkg::pm_max_t lvl1_s [`PM_GROUP_SIZE/2];
	pm_pkg::pm_max_t lvl2_s [`PM_GROUP_SIZE/4];

	//--------------------------------------------------------------------------
	// Leaves tagged with their absolute state number
	//--------------------------------------------------------------------------
	for (genvar k = 0; k < `PM_GROUP_SIZE; k++) begin : g_leaf
		assign leaf_s[k] = {
			pm_i[k*`PM_WIDTH +: `PM_WIDTH],
			pm_pkg::pm_state_t'(BASE_STATE + k)
		};
	end

	//--------------------------------------------------------------------------
	// Compare levels 8 -> 4 -> 2 -> 1
	//--------------------------------------------------------------------------

	// Neighbour pairs
	for (genvar k = 0; k < `PM_GROUP_SIZE/2; k++) begin : g_lvl1
		assign lvl1_s[k] = pm_pkg::pm_pick(
			leaf_s[2*k],
			leaf_s[2*k+1]
		);
	end

	// Quads
	for (genvar k = 0; k < `PM_GROUP_SIZE/4; k++) begin : g_lvl2
		assign lvl2_s[k] = pm_pkg::pm_pick(
			lvl1_s[2*k],
			lvl1_s[2*k+1]
		);
	end

	// Lower quad wins on equal metrics
	assign best_o = pm_pkg::pm_pick(
		lvl2_s[0],
		lvl2_s[1]
	);

endmodule

/* hdl/pm_max_tree.sv */
`timescale 1ns/1ps

`include "pm_consts.svh"

// Maximum over the active state range
module pm_max_tree (
	input  pm_pkg::pm_vec_t  pm_i,
	input  pm_pkg::pm_mode_t mode_i,
	output pm_pkg::pm_max_t  best_o
);

	// Group results, then the 16, 32 and 64 state levels
	pm_pkg::pm_max_t grp_s [`PM_NUM_GROUPS];
	pm_pkg::pm_max_t l16_s [`PM_NUM_GROUPS/2];
	pm_pkg::pm_max_t l32_s [`PM_NUM_GROUPS/4];
	pm_pkg::pm_max_t l64_s;

	// Number of active states for the current mode
	int act_cnt_s;

	//--------------------------------------------------------------------------
	// First level, eight states per group
	//--------------------------------------------------------------------------
	for (genvar g = 0; g < `PM_NUM_GROUPS; g++) begin : g_group
		pm_max_group #(
			.BASE_STATE (g*`PM_GROUP_SIZE)
		) pm_max_group_i (
			.pm_i   (pm_i[g*`PM_GROUP_SIZE*`PM_WIDTH +: `PM_GROUP_SIZE*`PM_WIDTH]),
			.best_o (grp_s[g])
		);
	end

	//--------------------------------------------------------------------------
	// Upper levels
	//--------------------------------------------------------------------------

	// States 0-15, 16-31, 32-47, 48-63
	for (genvar g = 0; g < `PM_NUM_GROUPS/2; g++) begin : g_l16
		assign l16_s[g] = pm_pkg::pm_pick(
			grp_s[2*g],
			grp_s[2*g+1]
		);
	end

	// States 0-31 and 32-63
	for (genvar g = 0; g < `PM_NUM_GROUPS/4; g++) begin : g_l32
		assign l32_s[g] = pm_pkg::pm_pick(
			l16_s[2*g],
			l16_s[2*g+1]
		);
	end

	// Full trellis
	assign l64_s = pm_pkg::pm_pick(
		l32_s[0],
		l32_s[1]
	);

	//--------------------------------------------------------------------------
	// Mode select
	//--------------------------------------------------------------------------

	// Each reduced range starts at state 0, so the lowest node of its level
	// already covers exactly the active states
	always_comb begin
		case (mode_i)
			`PM_MODE_64: begin
				best_o    = l64_s;
				act_cnt_s = `PM_NUM_STATES;
			end
			`PM_MODE_32: begin
				best_o    = l32_s[0];
				act_cnt_s = `PM_NUM_STATES/2;
			end
			`PM_MODE_16: begin
				best_o    = l16_s[0];
				act_cnt_s = `PM_NUM_STATES/4;
			end
			default: begin
				best_o    = grp_s[0];
				act_cnt_s = `PM_GROUP_SIZE;
			end
		endcase

		// Winner must come from an active state
		a_state_in_range: assert (int'(best_o.state) < act_cnt_s)
			else $error("max state %0d outside active range", best_o.state);
	end

endmodule

/* hdl/pm_norm_regs.sv */
`timescale 1ns/1ps

`include "pm_consts.svh"

// Normalized metric registers and winning state register
module pm_norm_regs (
	input  logic              clk_i,
	input  logic              rst_an_i,
	input  logic              rst_sync_i,
	input  logic              en_i,
	input  pm_pkg::pm_mode_t  mode_i,
	input  pm_pkg::pm_vec_t   pm_i,
	input  pm_pkg::pm_max_t   best_i,
	output pm_pkg::pm_vec_t   pm_o,
	output pm_pkg::pm_state_t max_state_o
);

	logic [`PM_NUM_STATES-1:0] upd_mask_s;
	pm_pkg::pm_metric_t        pm_q [`PM_NUM_STATES];
	pm_pkg::pm_state_t         max_state_q;

	//--------------------------------------------------------------------------
	// Active state mask
	//--------------------------------------------------------------------------
	always_comb begin
		case (mode_i)
			`PM_MODE_64: upd_mask_s = {`PM_NUM_STATES{1'b1}};
			`PM_MODE_32: upd_mask_s = {`PM_NUM_STATES{1'b1}} >> (`PM_NUM_STATES/2);
			`PM_MODE_16: upd_mask_s = {`PM_NUM_STATES{1'b1}} >> (`PM_NUM_STATES*3/4);
			default:     upd_mask_s = {`PM_NUM_STATES{1'b1}} >> (`PM_NUM_STATES-`PM_GROUP_SIZE);
		endcase
	end

	//--------------------------------------------------------------------------
	// Per-state subtract, clip and register
	//--------------------------------------------------------------------------
	for (genvar s = 0; s < `PM_NUM_STATES; s++) begin : g_state
		logic signed [`PM_WIDTH:0] diff_s;
		pm_pkg::pm_metric_t        norm_s;

		// One extra bit so the difference cannot wrap
		assign diff_s = {pm_i[(s+1)*`PM_WIDTH-1], pm_i[s*`PM_WIDTH +: `PM_WIDTH]} -
			{best_i.metric[`PM_WIDTH-1], best_i.metric};

		// Never positive, so only the lower bound needs a clamp
		assign norm_s = (diff_s < `PM_SAT_MIN) ?
			pm_pkg::pm_metric_t'(`PM_SAT_MIN) : diff_s[`PM_WIDTH-1:0];

		always_ff @(posedge clk_i or negedge rst_an_i) begin
			if (!rst_an_i) begin
				pm_q[s] <= '0;
			end else if (rst_sync_i) begin
				pm_q[s] <= '0;
			end else if (en_i && upd_mask_s[s]) begin
				pm_q[s] <= norm_s;
			end
		end

		assign pm_o[s*`PM_WIDTH +: `PM_WIDTH] = pm_q[s];

		// Active result lies between the lower clamp and zero
		a_active_bound: assert property (
			@(posedge clk_i) disable iff (!rst_an_i)
			(en_i && !rst_sync_i && upd_mask_s[s]) |=>
				(pm_q[s] <= 0) && (pm_q[s] >= `PM_SAT_MIN) && (pm_q[s] < `PM_SAT_MAX)
		) else $error("state %0d out of bounds after update", s);

		a_inactive_hold: assert property (
			@(posedge clk_i) disable iff (!rst_an_i)
			(en_i && !rst_sync_i && !upd_mask_s[s]) |=> $stable(pm_q[s])
		) else $error("inactive state %0d changed", s);
	end

	//--------------------------------------------------------------------------
	// Winning state
	//--------------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge rst_an_i) begin
		if (!rst_an_i) begin
			max_state_q <= '0;
		end else if (rst_sync_i) begin
			max_state_q <= '0;
		end else if (en_i) begin
			max_state_q <= best_i.state;
		end
	end

	assign max_state_o = max_state_q;

endmodule

/* hdl/pm_normalize.sv */
`timescale 1ns/1ps

// Path metric normalizer for a 64-state Viterbi decoder
module pm_normalize (
	input  logic              clk_i,
	input  logic              rst_an_i,
	input  logic              rst_sync_i,
	input  logic              en_i,
	input  pm_pkg::pm_mode_t  mode_i,
	input  pm_pkg::pm_vec_t   pm_i,
	output pm_pkg::pm_vec_t   pm_o,
	output pm_pkg::pm_state_t max_state_o
);

	// Combinational maximum of the active range
	pm_pkg::pm_max_t best_s;

	//--------------------------------------------------------------------------
	// Max search
	//--------------------------------------------------------------------------
	pm_max_tree pm_max_tree_i (
		.pm_i   (pm_i),
		.mode_i (mode_i),
		.best_o (best_s)
	);

	//--------------------------------------------------------------------------
	// Normalize and register
	//--------------------------------------------------------------------------
	pm_norm_regs pm_norm_regs_i (
		.clk_i       (clk_i),
		.rst_an_i    (rst_an_i),
		.rst_sync_i  (rst_sync_i),
		.en_i        (en_i),
		.mode_i      (mode_i),
		.pm_i        (pm_i),
		.best_i      (best_s),
		.pm_o        (pm_o),
		.max_state_o (max_state_o)
	);

endmodule

/* testbench/tb_pm_normalize.sv */
`timescale 1ns/1ps

`include "pm_consts.svh"

module tb_pm_normalize;

	// Tests take well under TEST_CYCLES clock cycles
	localparam int TEST_CYCLES = 400;
	localparam int MAX_CYCLES  = 5 * TEST_CYCLES;

	logic              clk_i;
	logic              rst_an_i;
	logic              rst_sync_i;
	logic              en_i;
	pm_pkg::pm_mode_t  mode_i;
	pm_pkg::pm_vec_t   pm_i;
	pm_pkg::pm_vec_t   pm_o;
	pm_pkg::pm_state_t max_state_o;

	integer seed = 32'h7470;
	int     cycle_cnt = 0;

	// Expected register contents
	pm_pkg::pm_metric_t exp_pm [`PM_NUM_STATES];
	pm_pkg::pm_state_t  exp_state;

	pm_normalize pm_normalize_i (
		.clk_i       (clk_i),
		.rst_an_i    (rst_an_i),
		.rst_sync_i  (rst_sync_i),
		.en_i        (en_i),
		.mode_i      (mode_i),
		.pm_i        (pm_i),
		.pm_o        (pm_o),
		.max_state_o (max_state_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run aborted");
	endtask

	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			stop_with_failure($sformatf("timeout after %0d cycles", cycle_cnt));
		end
	end

	//--------------------------------------------------------------------------
	// Helpers and reference model
	//--------------------------------------------------------------------------
	function automatic int active_count(input pm_pkg::pm_mode_t mode);
		case (mode)
			`PM_MODE_64: return 64;
			`PM_MODE_32: return 32;
			`PM_MODE_16: return 16;
			default:     return 8;
		endcase
	endfunction

	function automatic pm_pkg::pm_metric_t get_metric(input pm_pkg::pm_vec_t v, input int s);
		return pm_pkg::pm_metric_t'(v[s*`PM_WIDTH +: `PM_WIDTH]);
	endfunction

	task automatic random_vec(output pm_pkg::pm_vec_t v);
		for (int i = 0; i < `PM_NUM_STATES*`PM_WIDTH/32; i++) begin
			v[i*32 +: 32] = $random(seed);
		end
	endtask

	// Linear scan, strict greater keeps the lowest index on ties
	task automatic model_step(
		input pm_pkg::pm_vec_t  vec,
		input pm_pkg::pm_mode_t mode,
		input logic             en,
		input logic             sync
	);
		int                 act;
		int                 best_s;
		int                 diff;
		pm_pkg::pm_metric_t best_m;
		act = active_count(mode);
		if (sync) begin
			for (int s = 0; s < `PM_NUM_STATES; s++) begin
				exp_pm[s] = '0;
			end
			exp_state = '0;
		end else if (en) begin
			best_s = 0;
			best_m = get_metric(vec, 0);
			for (int s = 1; s < act; s++) begin
				if (get_metric(vec, s) > best_m) begin
					best_m = get_metric(vec, s);
					best_s = s;
				end
			end
			for (int s = 0; s < act; s++) begin
				diff = int'(get_metric(vec, s)) - int'(best_m);
				if (diff < -128) begin
					diff = -128;
				end
				exp_pm[s] = pm_pkg::pm_metric_t'(diff);
			end
			exp_state = pm_pkg::pm_state_t'(best_s);
		end
	endtask

	task automatic check_metric(
		input string              name,
		input int                 s,
		input pm_pkg::pm_metric_t exp,
		input pm_pkg::pm_metric_t act
	);
		if (act !== exp) begin
			stop_with_failure($sformatf("mismatch %s state %0d: expected %0d, actual %0d",
				name, s, exp, act));
		end
	endtask

	task automatic check_state(
		input string             name,
		input pm_pkg::pm_state_t exp,
		input pm_pkg::pm_state_t act
	);
		if (act !== exp) begin
			stop_with_failure($sformatf("mismatch %s max state: expected %0d, actual %0d",
				name, exp, act));
		end
	endtask

	task automatic compare_outputs(input string name);
		for (int s = 0; s < `PM_NUM_STATES; s++) begin
			check_metric(name, s, exp_pm[s], get_metric(pm_o, s));
		end
		check_state(name, exp_state, max_state_o);
	endtask

	// Drive on the falling edge, check after the next rising edge
	task automatic drive_cycle(
		input string            name,
		input pm_pkg::pm_vec_t  vec,
		input pm_pkg::pm_mode_t mode,
		input logic             en,
		input logic             sync
	);
		pm_i       = vec;
		mode_i     = mode;
		en_i       = en;
		rst_sync_i = sync;
		model_step(vec, mode, en, sync);
		@(negedge clk_i);
		compare_outputs(name);
	endtask

	//--------------------------------------------------------------------------
	// Directed tests
	//--------------------------------------------------------------------------
	task automatic reset_values();
		compare_outputs("reset");
		drive_cycle("reset idle", '0, `PM_MODE_64, 1'b0, 1'b0);
	endtask

	task automatic full_mode_random();
		pm_pkg::pm_vec_t v;
		for (int i = 0; i < 20; i++) begin
			random_vec(v);
			drive_cycle("full mode", v, `PM_MODE_64, 1'b1, 1'b0);
		end
	endtask

	task automatic reduced_mode_random();
		pm_pkg::pm_vec_t  v;
		pm_pkg::pm_mode_t modes [3];
		modes = '{`PM_MODE_32, `PM_MODE_16, `PM_MODE_8};
		foreach (modes[m]) begin
			for (int i = 0; i < 5; i++) begin
				random_vec(v);
				drive_cycle("reduced mode", v, modes[m], 1'b1, 1'b0);
			end
		end
	endtask

	task automatic saturation_clip();
		pm_pkg::pm_vec_t v;
		for (int s = 0; s < `PM_NUM_STATES; s++) begin
			v[s*`PM_WIDTH +: `PM_WIDTH] = (s % 2 == 0) ? 8'h80 : 8'h9c;
		end
		v[5*`PM_WIDTH +: `PM_WIDTH]  = 8'h7f;
		// Just inside and exactly at the clamp
		v[40*`PM_WIDTH +: `PM_WIDTH] = 8'h00;
		v[41*`PM_WIDTH +: `PM_WIDTH] = 8'hff;
		drive_cycle("saturation", v, `PM_MODE_64, 1'b1, 1'b0);
		check_metric("saturation", 5, 8'sd0, get_metric(pm_o, 5));
		check_metric("saturation", 0, -8'sd128, get_metric(pm_o, 0));
		check_metric("saturation", 40, -8'sd127, get_metric(pm_o, 40));
		check_state("saturation", 6'd5, max_state_o);
	endtask

	task automatic tie_case(
		input pm_pkg::pm_mode_t mode,
		input int               a,
		input int               b,
		input int               c,
		input int               win
	);
		pm_pkg::pm_vec_t v;
		for (int s = 0; s < `PM_NUM_STATES; s++) begin
			v[s*`PM_WIDTH +: `PM_WIDTH] = pm_pkg::pm_metric_t'(($random(seed) & 32'h3f) - 64);
		end
		v[a*`PM_WIDTH +: `PM_WIDTH] = 8'd100;
		v[b*`PM_WIDTH +: `PM_WIDTH] = 8'd100;
		v[c*`PM_WIDTH +: `PM_WIDTH] = 8'd100;
		drive_cycle("ties", v, mode, 1'b1, 1'b0);
		check_state("ties", pm_pkg::pm_state_t'(win), max_state_o);
	endtask

	task automatic tie_break();
		tie_case(`PM_MODE_64, 50, 13, 27, 13);
		tie_case(`PM_MODE_64, 63, 8, 40, 8);
		// State 40 is outside the 32 state range
		tie_case(`PM_MODE_32, 40, 31, 17, 17);
		tie_case(`PM_MODE_8, 6, 3, 12, 3);
	endtask

	task automatic enable_and_clear();
		pm_pkg::pm_vec_t v;
		random_vec(v);
		drive_cycle("enable low", v, `PM_MODE_64, 1'b0, 1'b0);
		random_vec(v);
		drive_cycle("sync clear", v, `PM_MODE_64, 1'b1, 1'b1);
		random_vec(v);
		drive_cycle("after clear", v, `PM_MODE_16, 1'b1, 1'b0);
	endtask

	//--------------------------------------------------------------------------
	// Sequence
	//--------------------------------------------------------------------------
	initial begin
		rst_an_i   = 1'b0;
		rst_sync_i = 1'b0;
		en_i       = 1'b0;
		mode_i     = `PM_MODE_64;
		pm_i       = '0;
		for (int s = 0; s < `PM_NUM_STATES; s++) begin
			exp_pm[s] = '0;
		end
		exp_state = '0;
		repeat (4) @(posedge clk_i);
		@(negedge clk_i);
		rst_an_i = 1'b1;

		reset_values();
		full_mode_random();
		reduced_mode_random();
		saturation_clip();
		tie_break();
		enable_and_clear();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+hdl
hdl/pm_pkg.sv
hdl/pm_max_group.sv
hdl/pm_max_tree.sv
hdl/pm_norm_regs.sv
hdl/pm_normalize.sv
testbench/tb_pm_normalize.sv

/* run.sh */
#!/bin/sh
# Build and run the normalizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_pm_normalize -o tb_sim

out=$(./obj_dir/tb_sim) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
